/* src/cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [3:0] regIdxT;

    // 5-bit opcode field, top of the instruction word
    typedef enum logic [4:0] {
        opLd  = 5'd0,
        opLdi = 5'd1,
        opSt  = 5'd2,
        opAdd = 5'd3,
        opSub = 5'd4,
        opAnd = 5'd5,
        opOr  = 5'd6,
        opShr = 5'd7,
        opShl = 5'd8,
        opMul = 5'd9,
        opNeg = 5'd10,
        opNot = 5'd11,
        opBr  = 5'd12,
        opIn  = 5'd13,
        opOut = 5'd14,
        opNop = 5'd15
    } opcodeT;

    // ALU codes follow the opcodes where one exists
    typedef enum logic [4:0] {
        aluPass = 5'd0,  // Bus straight through to Z low
        aluAdd  = 5'd3,  // Y + bus
        aluSub  = 5'd4,  // Y - bus
        aluAnd  = 5'd5,
        aluOr   = 5'd6,
        aluShr  = 5'd7,  // Logical, Y by bus[4:0]
        aluShl  = 5'd8,  // Y by bus[4:0]
        aluMul  = 5'd9,  // Signed, full 64-bit product
        aluNeg  = 5'd10, // Two's complement of bus
        aluNot  = 5'd11, // Bitwise inversion of bus
        aluInc  = 5'd16  // Bus + 1, used for the PC
    } aluOpT;

    // Branch condition, carried in the low bits of rb
    typedef enum logic [1:0] {
        condZero     = 2'd0,
        condNonzero  = 2'd1,
        condPositive = 2'd2,
        condNegative = 2'd3
    } condT;

    typedef struct packed {
        opcodeT      opcode;
        regIdxT      ra;
        regIdxT      rb;
        regIdxT      rc;
        logic [14:0] c;
    } instrT;

endpackage

/* src/busPkg.sv */
package busPkg;

    // Exactly one driver on the shared bus per cycle
    typedef enum logic [3:0] {
        srcNone   = 4'd0,
        srcReg    = 4'd1,
        srcPc     = 4'd2,
        srcZHigh  = 4'd3,
        srcZLow   = 4'd4,
        srcHi     = 4'd5,
        srcLo     = 4'd6,
        srcMdr    = 4'd7,
        srcInPort = 4'd8,
        srcC      = 4'd9
    } busSrcT;

    // One control step, every strobe lasts one clock
    typedef struct packed {
        logic pcIn;
        logic irIn;
        logic yIn;
        logic zIn;        // Loads Z high and Z low together
        logic hiIn;
        logic loIn;
        logic marIn;
        logic mdrIn;
        logic outPortIn;
        logic conIn;
        logic gra;        // Register select from ra
        logic grb;
        logic grc;
        logic rIn;
        logic rOut;
        logic baOut;      // R0 reads as zero
        logic read;       // MDR takes memory instead of bus
        logic write;
        cpuPkg::aluOpT aluOp;
        busSrcT busSrc;
    } ctrlT;

endpackage

/* src/instrDecode.sv */
module instrDecode (
    input  logic           clk,
    input  logic           reset,
    input  busPkg::ctrlT   ctrl,
    input  cpuPkg::wordT   busData,
    output cpuPkg::instrT  instr,
    output cpuPkg::regIdxT regSel,
    output cpuPkg::wordT   cSext
);

    cpuPkg::instrT ir;

    // Instruction register
    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (ctrl.irIn) begin
            ir <= cpuPkg::instrT'(busData);
        end
    end

    assign instr = ir;

    // Select and encode, one field per strobe
    always_comb begin
        if (ctrl.gra) begin
            regSel = ir.ra;
        end else if (ctrl.grb) begin
            regSel = ir.rb;
        end else if (ctrl.grc) begin
            regSel = ir.rc;
        end else begin
            regSel = '0;
        end
    end

    // Constant C widened with its sign bit
    assign cSext = {{17{ir.c[14]}}, ir.c};

endmodule

/* src/registerFile.sv */
module registerFile (
    input  logic           clk,
    input  logic           reset,
    input  busPkg::ctrlT   ctrl,
    input  cpuPkg::regIdxT regSel,
    input  cpuPkg::wordT   busData,
    output cpuPkg::wordT   readData
);

    localparam int numRegs = 16;

    cpuPkg::wordT regs [numRegs];
    logic         baseZero;

    // General registers R0 to R15
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rIn) begin
            regs[regSel] <= busData;
        end
    end

    // Base-address out turns R0 into a zero offset base
    assign baseZero = ctrl.baOut && (regSel == '0);

    always_comb begin
        if (baseZero) begin
            readData = '0;
        end else if (ctrl.rOut || ctrl.baOut) begin
            readData = regs[regSel];
        end else begin
            readData = '0; // No register output this step
        end
    end

endmodule

/* src/aluExecute.sv */
module aluExecute (
    input  logic         clk,
    input  logic         reset,
    input  busPkg::ctrlT ctrl,
    input  cpuPkg::wordT busData,
    output cpuPkg::wordT zHigh,
    output cpuPkg::wordT zLow,
    output cpuPkg::wordT hiData,
    output cpuPkg::wordT loData
);

    cpuPkg::wordT y;
    cpuPkg::wordT zHi;
    cpuPkg::wordT zLo;
    cpuPkg::wordT hi;
    cpuPkg::wordT lo;
    logic [63:0]  aluResult;
    logic signed [63:0] product;
    logic [4:0]   shamt;

    // Y holds operand A for the next step
    always_ff @(posedge clk) begin
        if (reset) begin
            y <= '0;
        end else if (ctrl.yIn) begin
            y <= busData;
        end
    end

    assign shamt = busData[4:0];
    assign product = $signed(y) * $signed(busData);

    always_comb begin
        aluResult = '0;
        case (ctrl.aluOp)
            cpuPkg::aluAdd:  aluResult = {32'b0, y + busData};
            cpuPkg::aluSub:  aluResult = {32'b0, y - busData};
            cpuPkg::aluAnd:  aluResult = {32'b0, y & busData};
            cpuPkg::aluOr:   aluResult = {32'b0, y | busData};
            cpuPkg::aluShr:  aluResult = {32'b0, y >> shamt};
            cpuPkg::aluShl:  aluResult = {32'b0, y << shamt};
            cpuPkg::aluNeg:  aluResult = {32'b0, -busData};
            cpuPkg::aluNot:  aluResult = {32'b0, ~busData};
            cpuPkg::aluMul:  aluResult = product;
            cpuPkg::aluInc:  aluResult = {32'b0, busData + 32'd1};
            default:         aluResult = {32'b0, busData}; // Pass
        endcase
    end

    // Z high and low always load as a pair
    always_ff @(posedge clk) begin
        if (reset) begin
            zHi <= '0;
            zLo <= '0;
        end else if (ctrl.zIn) begin
            zHi <= aluResult[63:32];
            zLo <= aluResult[31:0];
        end
    end

    // HI and LO take the product halves off the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (ctrl.hiIn) hi <= busData;
            if (ctrl.loIn) lo <= busData;
        end
    end

    assign zHigh  = zHi;
    assign zLow   = zLo;
    assign hiData = hi;
    assign loData = lo;

endmodule

/* src/branchCondition.sv */
module branchCondition (
    input  logic          clk,
    input  logic          reset,
    input  busPkg::ctrlT  ctrl,
    input  cpuPkg::instrT instr,
    input  cpuPkg::wordT  busData,
    output logic          con
);

    cpuPkg::condT cond;
    logic         isZero;
    logic         condMet;

    assign cond   = cpuPkg::condT'(instr.rb[1:0]); // C2 bits of brnz form
    assign isZero = (busData == '0);

    always_comb begin
        case (cond)
            cpuPkg::condZero:     condMet = isZero;
            cpuPkg::condNonzero:  condMet = !isZero;
            cpuPkg::condPositive: condMet = !busData[31] && !isZero;
            default:              condMet = busData[31]; // Negative
        endcase
    end

    // CON flip-flop
    always_ff @(posedge clk) begin
        if (reset) begin
            con <= 1'b0;
        end else if (ctrl.conIn) begin
            con <= condMet;
        end
    end

endmodule

/* src/memoryPort.sv */
module memoryPort #(
    parameter int memAddrBits = 9
) (
    input  logic         clk,
    input  logic         reset,
    input  busPkg::ctrlT ctrl,
    input  cpuPkg::wordT busData,
    output cpuPkg::wordT pcData,
    output cpuPkg::wordT mdrData
);

    localparam int memWords = 2 ** memAddrBits;

    cpuPkg::wordT           pc;
    logic [memAddrBits-1:0] mar;
    cpuPkg::wordT           mdr;
    cpuPkg::wordT           mem [memWords];
    cpuPkg::wordT           memWord;

    // Program counter, incremented through the ALU
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pcIn) begin
            pc <= busData;
        end
    end

    // MAR keeps only the word address bits
    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
        end else if (ctrl.marIn) begin
            mar <= busData[memAddrBits-1:0];
        end
    end

    assign memWord = mem[mar]; // Asynchronous read

    // MDR source is memory on a read, else the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            mdr <= '0;
        end else if (ctrl.mdrIn) begin
            if (ctrl.read) begin
                mdr <= memWord;
            end else begin
                mdr <= busData;
            end
        end
    end

    // Write stores MDR at the MAR address
    always_ff @(posedge clk) begin
        if (ctrl.write) begin
            mem[mar] <= mdr;
        end
    end

    assign pcData  = pc;
    assign mdrData = mdr;

endmodule

/* src/datapath.sv */
module datapath #(
    parameter int memAddrBits = 9
) (
    input  logic         clk,
    input  logic         reset,
    input  busPkg::ctrlT ctrl,
    input  cpuPkg::wordT inPortData,
    output cpuPkg::wordT busData,
    output cpuPkg::wordT pcData,
    output cpuPkg::wordT outPortData,
    output logic         con
);

    cpuPkg::instrT  instr;
    cpuPkg::regIdxT regSel;
    cpuPkg::wordT   cSext;
    cpuPkg::wordT   regReadData;
    cpuPkg::wordT   zHigh;
    cpuPkg::wordT   zLow;
    cpuPkg::wordT   hiData;
    cpuPkg::wordT   loData;
    cpuPkg::wordT   mdrData;
    cpuPkg::wordT   outPort;

    // Single shared bus
    always_comb begin
        case (ctrl.busSrc)
            busPkg::srcReg:    busData = regReadData;
            busPkg::srcPc:     busData = pcData;
            busPkg::srcZHigh:  busData = zHigh;
            busPkg::srcZLow:   busData = zLow;
            busPkg::srcHi:     busData = hiData;
            busPkg::srcLo:     busData = loData;
            busPkg::srcMdr:    busData = mdrData;
            busPkg::srcInPort: busData = inPortData;
            busPkg::srcC:      busData = cSext;
            default:           busData = '0; // Nothing drives
        endcase
    end

    // Output port register
    always_ff @(posedge clk) begin
        if (reset) begin
            outPort <= '0;
        end else if (ctrl.outPortIn) begin
            outPort <= busData;
        end
    end

    assign outPortData = outPort;

    instrDecode i_instrDecode (
        .clk, .reset, .ctrl, .busData,
        .instr, .regSel, .cSext
    );

    registerFile i_registerFile (
        .clk, .reset, .ctrl, .regSel, .busData,
        .readData (regReadData)
    );

    aluExecute i_aluExecute (
        .clk, .reset, .ctrl, .busData,
        .zHigh, .zLow, .hiData, .loData
    );

    branchCondition i_branchCondition (
        .clk, .reset, .ctrl, .instr, .busData, .con
    );

    memoryPort #(
        .memAddrBits (memAddrBits)
    ) i_memoryPort (
        .clk, .reset, .ctrl, .busData,
        .pcData, .mdrData
    );

endmodule

/* dv/datapath_assertions.sv */
module datapathAssertions (
    input logic         clk,
    input logic         reset,
    input busPkg::ctrlT ctrl,
    input cpuPkg::wordT pcData,
    input logic         con
);

    timeunit 1ns;
    timeprecision 1ps;

    logic loadActive;
    int   failures = 0;

    // Any strobe that takes its value from the bus
    assign loadActive = ctrl.pcIn || ctrl.irIn || ctrl.yIn || ctrl.zIn || ctrl.hiIn
                     || ctrl.loIn || ctrl.marIn || ctrl.outPortIn || ctrl.conIn
                     || ctrl.rIn || (ctrl.mdrIn && !ctrl.read);

    busDriven: assert property (
        @(posedge clk) disable iff (reset)
        loadActive |-> ctrl.busSrc != busPkg::srcNone
    ) else begin
        failures++;
        $error("Load strobe active with no bus driver");
    end

    readWriteExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(ctrl.read && ctrl.write)
    ) else begin
        failures++;
        $error("Memory read and write in the same step");
    end

    // First cycle out of reset
    resetState: assert property (
        @(posedge clk)
        $fell(reset) |-> (con == 1'b0) && (pcData == '0)
    ) else begin
        failures++;
        $error("PC or CON not cleared by reset");
    end

endmodule

bind datapath datapathAssertions i_datapathAssertions (
    .clk, .reset, .ctrl, .pcData, .con
);

/* dv/datapathTb.sv */
module datapathTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int memAddrBits = 9;

    typedef enum logic [2:0] {chkNone, chkBus, chkPc, chkOut, chkCon} checkT;

    typedef struct packed {
        busPkg::ctrlT ctrl;
        cpuPkg::wordT inPort;
        checkT        sel;
        cpuPkg::wordT expected;
    } rowT;

    logic         clk;
    logic         reset;
    busPkg::ctrlT ctrl;
    cpuPkg::wordT inPortData;
    cpuPkg::wordT busData;
    cpuPkg::wordT pcData;
    cpuPkg::wordT outPortData;
    logic         con;

    rowT rows[$];
    int  errorCount = 0;
    int  cycles = 0;
    int  limit = 0;
    bit  running = 0;

    datapath #(.memAddrBits(memAddrBits)) i_datapath (
        .clk, .reset, .ctrl, .inPortData, .busData, .pcData, .outPortData, .con
    );

    always #4 clk = ~clk;

    task automatic failRun(input string what);
        errorCount++;
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkWord(input string name, input cpuPkg::wordT got,
                             input cpuPkg::wordT exp);
        if (got !== exp) begin
            failRun($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkAssertions();
        if (i_datapath.i_datapathAssertions.failures != 0) begin
            failRun("A bound assertion on the datapath failed");
        end
    endtask

    function automatic busPkg::ctrlT makeStep(input busPkg::busSrcT src,
                                              input cpuPkg::aluOpT op);
        busPkg::ctrlT c;
        c = '0;
        c.busSrc = src;
        c.aluOp = op;
        return c;
    endfunction

    function automatic cpuPkg::wordT makeInstr(input cpuPkg::opcodeT op,
                                               input cpuPkg::regIdxT ra,
                                               input cpuPkg::regIdxT rb,
                                               input logic [14:0] c);
        cpuPkg::instrT i;
        i.opcode = op;
        i.ra = ra;
        i.rb = rb;
        i.rc = '0;
        i.c = c;
        return cpuPkg::wordT'(i);
    endfunction

    task automatic addRow(input busPkg::ctrlT c, input cpuPkg::wordT in,
                          input checkT sel, input cpuPkg::wordT exp);
        rows.push_back('{ctrl: c, inPort: in, sel: sel, expected: exp});
    endtask

    task automatic loadIr(input cpuPkg::wordT word);
        busPkg::ctrlT c;
        c = makeStep(busPkg::srcInPort, cpuPkg::aluPass);
        c.irIn = 1'b1;
        addRow(c, word, chkNone, '0);
    endtask

    // Input port value into R[ra]
    task automatic writeReg(input cpuPkg::wordT value);
        busPkg::ctrlT c;
        c = makeStep(busPkg::srcInPort, cpuPkg::aluPass);
        c.gra = 1'b1;
        c.rIn = 1'b1;
        addRow(c, value, chkNone, '0);
    endtask

    task automatic buildIoRows();
        busPkg::ctrlT c;
        cpuPkg::wordT v;
        v = $urandom;
        loadIr(makeInstr(cpuPkg::opIn, 4'd5, 4'd0, '0));
        writeReg(v);
        c = makeStep(busPkg::srcReg, cpuPkg::aluPass);
        c.gra = 1'b1;
        c.rOut = 1'b1;
        c.outPortIn = 1'b1;
        addRow(c, '0, chkBus, v);
        addRow(makeStep(busPkg::srcNone, cpuPkg::aluPass), '0, chkOut, v);
        // R0 holds a value but reads zero as a base
        loadIr(makeInstr(cpuPkg::opLd, 4'd0, 4'd0, '0));
        writeReg($urandom | 32'h1);
        c = makeStep(busPkg::srcReg, cpuPkg::aluPass);
        c.gra = 1'b1;
        c.baOut = 1'b1;
        addRow(c, '0, chkBus, '0);
    endtask

    task automatic buildMemoryRows();
        busPkg::ctrlT c;
        cpuPkg::wordT addr;
        cpuPkg::wordT word;
        addr = $urandom % (1 << memAddrBits);
        word = $urandom;
        c = makeStep(busPkg::srcInPort, cpuPkg::aluPass);
        c.marIn = 1'b1;
        addRow(c, addr, chkNone, '0);
        c = makeStep(busPkg::srcInPort, cpuPkg::aluPass);
        c.mdrIn = 1'b1;
        addRow(c, word, chkNone, '0);
        c = makeStep(busPkg::srcNone, cpuPkg::aluPass);
        c.write = 1'b1;
        addRow(c, '0, chkNone, '0);
        c = makeStep(busPkg::srcInPort, cpuPkg::aluPass);
        c.pcIn = 1'b1;
        addRow(c, addr, chkNone, '0);
        // Three-step fetch
        c = makeStep(busPkg::srcPc, cpuPkg::aluInc);
        c.marIn = 1'b1;
        c.zIn = 1'b1;
        addRow(c, '0, chkBus, addr);
        c = makeStep(busPkg::srcZLow, cpuPkg::aluPass);
        c.pcIn = 1'b1;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        addRow(c, '0, chkBus, addr + 32'd1);
        c = makeStep(busPkg::srcMdr, cpuPkg::aluPass);
        c.irIn = 1'b1;
        addRow(c, '0, chkBus, word);
        addRow(makeStep(busPkg::srcNone, cpuPkg::aluPass), '0, chkPc, addr + 32'd1);
    endtask

    // Y <= a, Z <= Y op b
    task automatic aluSteps(input cpuPkg::wordT a, input cpuPkg::wordT b,
                            input cpuPkg::aluOpT op);
        busPkg::ctrlT c;
        c = makeStep(busPkg::srcInPort, cpuPkg::aluPass);
        c.yIn = 1'b1;
        addRow(c, a, chkNone, '0);
        c = makeStep(busPkg::srcInPort, op);
        c.zIn = 1'b1;
        addRow(c, b, chkNone, '0);
    endtask

    task automatic buildAluRows();
        busPkg::ctrlT c;
        cpuPkg::wordT a;
        cpuPkg::wordT b;
        cpuPkg::wordT exp;
        logic [63:0]  prod;
        cpuPkg::aluOpT ops [8] = '{cpuPkg::aluAdd, cpuPkg::aluSub, cpuPkg::aluAnd,
            cpuPkg::aluOr, cpuPkg::aluShr, cpuPkg::aluShl, cpuPkg::aluNeg, cpuPkg::aluNot};
        for (int i = 0; i < 8; i++) begin
            a = $urandom;
            b = $urandom;
            case (i)
                0: exp = a + b;
                1: exp = a - b;
                2: exp = a & b;
                3: exp = a | b;
                4: exp = a >> b[4:0];
                5: exp = a << b[4:0];
                6: exp = ~b + 32'd1;
                default: exp = ~b;
            endcase
            aluSteps(a, b, ops[i]);
            addRow(makeStep(busPkg::srcZLow, cpuPkg::aluPass), '0, chkBus, exp);
        end
        a = $urandom;
        b = $urandom;
        prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        aluSteps(a, b, cpuPkg::aluMul);
        c = makeStep(busPkg::srcZHigh, cpuPkg::aluPass);
        c.hiIn = 1'b1;
        addRow(c, '0, chkNone, '0);
        c = makeStep(busPkg::srcZLow, cpuPkg::aluPass);
        c.loIn = 1'b1;
        addRow(c, '0, chkNone, '0);
        addRow(makeStep(busPkg::srcHi, cpuPkg::aluPass), '0, chkBus, prod[63:32]);
        addRow(makeStep(busPkg::srcLo, cpuPkg::aluPass), '0, chkBus, prod[31:0]);
    endtask

    task automatic buildBranchRows();
        busPkg::ctrlT c;
        cpuPkg::wordT values [3];
        logic         exp;
        // Zero, positive and negative in that order
        values[0] = '0;
        values[1] = ($urandom & 32'h7fff_ffff) | 32'h1;
        values[2] = $urandom | 32'h8000_0000;
        foreach (values[v]) begin
            for (int cond = 0; cond < 4; cond++) begin
                case (cond)
                    0: exp = (v == 0);
                    1: exp = (v != 0);
                    2: exp = (v == 1);
                    default: exp = (v == 2);
                endcase
                loadIr(makeInstr(cpuPkg::opBr, 4'd3, cpuPkg::regIdxT'(cond), '0));
                writeReg(values[v]);
                c = makeStep(busPkg::srcReg, cpuPkg::aluPass);
                c.gra = 1'b1;
                c.rOut = 1'b1;
                c.conIn = 1'b1;
                addRow(c, '0, chkNone, '0);
                addRow(makeStep(busPkg::srcNone, cpuPkg::aluPass), '0, chkCon,
                       cpuPkg::wordT'(exp));
            end
        end
    endtask

    task automatic buildTargetRows();
        busPkg::ctrlT c;
        cpuPkg::wordT pc;
        int           offset;
        logic [14:0]  cs [2];
        cs[0] = ($urandom & 15'h3fff) | 15'h1;
        cs[1] = $urandom | 15'h4000; // Negative offset
        foreach (cs[k]) begin
            pc = $urandom & 32'h00ff_ffff;
            // Two's complement value of the 15-bit field
            offset = cs[k][14] ? int'(cs[k]) - 32768 : int'(cs[k]);
            loadIr(makeInstr(cpuPkg::opBr, 4'd3, 4'd1, cs[k]));
            c = makeStep(busPkg::srcInPort, cpuPkg::aluPass);
            c.pcIn = 1'b1;
            addRow(c, pc, chkNone, '0);
            c = makeStep(busPkg::srcPc, cpuPkg::aluPass);
            c.yIn = 1'b1;
            addRow(c, '0, chkNone, '0);
            c = makeStep(busPkg::srcC, cpuPkg::aluAdd);
            c.zIn = 1'b1;
            addRow(c, '0, chkNone, '0);
            c = makeStep(busPkg::srcZLow, cpuPkg::aluPass);
            c.pcIn = 1'b1;
            addRow(c, '0, chkNone, '0);
            addRow(makeStep(busPkg::srcNone, cpuPkg::aluPass), '0, chkPc,
                   pc + cpuPkg::wordT'(offset));
        end
    endtask

    always @(posedge clk) begin
        if (running) begin
            cycles <= cycles + 1;
            if (cycles >= limit) begin
                $display("Timeout: the step table did not finish in %0d cycles", limit);
                $display("Done: errors found");
                $fatal(1, "Timeout");
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        ctrl = '0;
        inPortData = '0;
        void'($urandom(32'hac86_0ce6));
        buildIoRows();
        buildMemoryRows();
        buildAluRows();
        buildBranchRows();
        buildTargetRows();
        limit = rows.size() + 3 + 20;
        running = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            ctrl <= rows[i].ctrl;
            inPortData <= rows[i].inPort;
            @(negedge clk); // Outputs settled mid-cycle
            case (rows[i].sel)
                chkBus: checkWord("busData", busData, rows[i].expected);
                chkPc:  checkWord("pcData", pcData, rows[i].expected);
                chkOut: checkWord("outPortData", outPortData, rows[i].expected);
                chkCon: checkFlag("con", con, rows[i].expected[0]);
                default: ;
            endcase
            checkAssertions();
        end
        @(negedge clk);
        checkAssertions();
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src.f */
src/cpuPkg.sv
src/busPkg.sv
src/instrDecode.sv
src/registerFile.sv
src/aluExecute.sv
src/branchCondition.sv
src/memoryPort.sv
src/datapath.sv
dv/datapath_assertions.sv
dv/datapathTb.sv

/* Bender.yml */
package:
  name: datapath

sources:
  - src/cpuPkg.sv
  - src/busPkg.sv
  - src/instrDecode.sv
  - src/registerFile.sv
  - src/aluExecute.sv
  - src/branchCondition.sv
  - src/memoryPort.sv
  - src/datapath.sv
  - target: test
    files:
      - dv/datapath_assertions.sv
      - dv/datapathTb.sv
